// ==== aluDispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluDispatch #(
    parameter int RS_SIZE = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           clr,
    rsIssueIf.dispatch     issue,
    output logic           aluReady,
    output rsPkg::dataWord lv,
    output rsPkg::dataWord rv,
    output rsPkg::aluOp    op,
    input  logic           aluSuccess,
    input  rsPkg::dataWord result,
    output logic           doneValid,
    output rsPkg::rsSlot   doneData,
    output rsPkg::dataWord doneResult
);
    import rsPkg::*;

    localparam int IDX_W = $clog2(RS_SIZE);

    logic             inFlight;
    logic [IDX_W-1:0] flightSlot;
    rsSlot            flightData;
    dataWord          nextLv;
    dataWord          nextRv;
    aluOp             nextOp;

    assign issue.take         = issue.pickValid && !inFlight;
    assign doneValid          = aluSuccess && inFlight; // Stray success ignored
    assign issue.releaseValid = doneValid;
    assign issue.releaseSlot  = flightSlot;
    assign doneData           = flightData;
    assign doneResult         = result;

    always_comb begin
        case (issue.pickData.name)
            ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                nextLv = issue.pickData.vj;
                nextRv = issue.pickData.vk;
            end
            LUI: begin
                nextLv = '0;
                nextRv = issue.pickData.imm;
            end
            AUIPC: begin
                nextLv = issue.pickData.vj;   // Carries the pc
                nextRv = {issue.pickData.imm[DATA_W-1:12], 12'b0};
            end
            JAL: begin
                nextLv = issue.pickData.vk;
                nextRv = {issue.pickData.imm[DATA_W-1:1], 1'b0};
            end
            default: begin                    // Immediates, memory, JALR
                nextLv = issue.pickData.vj;
                nextRv = issue.pickData.imm;
            end
        endcase

        case (issue.pickData.name)
            SUB:               nextOp = OP_SUB;
            AND, ANDI:         nextOp = OP_AND;
            OR, ORI:           nextOp = OP_OR;
            XOR, XORI:         nextOp = OP_XOR;
            SLL, SLLI:         nextOp = OP_SLL;
            SRL, SRLI:         nextOp = OP_SRL;
            SRA, SRAI:         nextOp = OP_SRA;
            SLT, SLTI, BLT:    nextOp = OP_LT;
            SLTU, SLTIU, BLTU: nextOp = OP_LTU;
            BGE:               nextOp = OP_GE;
            BGEU:              nextOp = OP_GEU;
            BEQ:               nextOp = OP_EQ;
            BNE:               nextOp = OP_NE;
            default:           nextOp = OP_ADD;  // Address and link sums too
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            inFlight <= 1'b0;
            aluReady <= 1'b0;
        end else begin
            aluReady <= issue.take;
            if (issue.take)
                inFlight <= 1'b1;
            else if (doneValid)
                inFlight <= 1'b0;
        end
    end

    // Operands hold until the next launch
    always_ff @(posedge clk) begin
        if (issue.take) begin
            flightSlot <= issue.pickSlot;
            flightData <= issue.pickData;
            lv         <= nextLv;
            rv         <= nextRv;
            op         <= nextOp;
        end
    end

    // No launch with an operand still owed by the ROB
    issueOperandsCaptured: assert property (@(posedge clk) disable iff (rst)
        issue.take |-> !issue.pickData.qjWait && !issue.pickData.qkWait);

endmodule

`default_nettype wire

// ==== commitUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module commitUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           clr,
    input  logic           doneValid,
    input  rsPkg::rsSlot   doneData,
    input  rsPkg::dataWord doneResult,
    output logic           robReady,
    output rsPkg::robTag   robAddr,
    output rsPkg::dataWord robA,
    output rsPkg::dataWord robRd,
    output logic           trainReady,
    output logic           trainResult
);
    import rsPkg::*;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            robReady   <= 1'b0;
            trainReady <= 1'b0;
        end else begin
            robReady   <= doneValid;
            trainReady <= doneValid && isBranch(doneData.name);
        end
    end

    always_ff @(posedge clk) begin
        if (doneValid) begin
            robAddr <= doneData.tag;
            if (isStore(doneData.name)) begin
                robA  <= doneData.vk;   // Store data
                robRd <= doneResult;    // Effective address
            end else begin
                robA  <= doneResult;
                robRd <= doneData.rd;
            end
            // Mispredict when prediction and outcome differ
            trainResult <= doneData.imm[0] ^ doneResult[0];
        end
    end

    // One write-back per finished operation
    singleDonePulse: assert property (@(posedge clk) disable iff (rst)
        doneValid |=> !doneValid);

endmodule

`default_nettype wire

// ==== reservationStation.sv ====
`timescale 1ns/1ns
`default_nettype none

module reservationStation #(
    parameter int RS_SIZE = 16
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     clr,
    input  logic                                     insValid,
    input  rsPkg::instrName                          name,
    input  rsPkg::dataWord                           vj,
    input  rsPkg::dataWord                           vk,
    input  rsPkg::robTag                             qj,
    input  logic                                     qjWait,
    input  rsPkg::robTag                             qk,
    input  logic                                     qkWait,
    input  rsPkg::dataWord                           imm,
    input  rsPkg::dataWord                           rd,
    input  rsPkg::robTag                             tag,
    input  logic [rsPkg::ROB_SIZE-1:0]               robValid,
    input  logic [rsPkg::ROB_SIZE*rsPkg::DATA_W-1:0] robValue,
    output logic                                     rsFull,
    output logic                                     aluReady,
    output rsPkg::dataWord                           lv,
    output rsPkg::dataWord                           rv,
    output rsPkg::aluOp                              op,
    input  logic                                     aluSuccess,
    input  rsPkg::dataWord                           result,
    output logic                                     robReady,
    output rsPkg::robTag                             robAddr,
    output rsPkg::dataWord                           robA,
    output rsPkg::dataWord                           robRd,
    output logic                                     trainReady,
    output logic                                     trainResult
);
    import rsPkg::*;

    rsSlot   insData;
    logic    doneValid;
    rsSlot   doneData;
    dataWord doneResult;

    rsIssueIf #(.RS_SIZE(RS_SIZE)) issueBus ();

    assign insData = '{name: name, vj: vj, vk: vk, imm: imm, qj: qj, qk: qk,
                       qjWait: qjWait, qkWait: qkWait, rd: rd, tag: tag};

    rsEntryTable #(
        .RS_SIZE (RS_SIZE)
    ) u_rsEntryTable (
        .clk (clk), .rst (rst), .clr (clr),
        .insValid (insValid),
        .insData  (insData),
        .robValid (robValid),
        .robValue (robValue),
        .full     (rsFull),
        .issue    (issueBus.entryTable)
    );

    aluDispatch #(
        .RS_SIZE (RS_SIZE)
    ) u_aluDispatch (
        .clk (clk), .rst (rst), .clr (clr),
        .issue      (issueBus.dispatch),
        .aluReady   (aluReady),
        .lv         (lv),
        .rv         (rv),
        .op         (op),
        .aluSuccess (aluSuccess),
        .result     (result),
        .doneValid  (doneValid),
        .doneData   (doneData),
        .doneResult (doneResult)
    );

    commitUnit u_commitUnit (
        .clk (clk), .rst (rst), .clr (clr),
        .doneValid   (doneValid),
        .doneData    (doneData),
        .doneResult  (doneResult),
        .robReady    (robReady),
        .robAddr     (robAddr),
        .robA        (robA),
        .robRd       (robRd),
        .trainReady  (trainReady),
        .trainResult (trainResult)
    );

endmodule

`default_nettype wire

// ==== rsEntryTable.sv ====
`timescale 1ns/1ns
`default_nettype none

module rsEntryTable #(
    parameter int RS_SIZE = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    clr,
    input  logic                                    insValid,
    input  rsPkg::rsSlot                            insData,
    input  logic [rsPkg::ROB_SIZE-1:0]              robValid,
    input  logic [rsPkg::ROB_SIZE*rsPkg::DATA_W-1:0] robValue,
    output logic                                    full,
    rsIssueIf.entryTable                            issue
);
    import rsPkg::*;

    localparam int IDX_W = $clog2(RS_SIZE);

    rsSlot              slots [RS_SIZE];
    rsSlot              insSlot;
    logic [RS_SIZE-1:0] busy;
    logic [RS_SIZE-1:0] ready;
    logic [RS_SIZE-1:0] issued;   // Sent to the ALU, waiting for release
    logic [IDX_W-1:0]   freeSlot;
    logic               hasFree;
    logic               doInsert;

    slotPicker #(
        .RS_SIZE (RS_SIZE)
    ) u_slotPicker (
        .busy      (busy),
        .ready     (ready),
        .freeSlot  (freeSlot),
        .hasFree   (hasFree),
        .readySlot (issue.pickSlot),
        .hasReady  (issue.pickValid)
    );

    assign full           = ~hasFree;
    assign doInsert       = insValid && hasFree; // Dropped when full
    assign issue.pickData = slots[issue.pickSlot];

    // Operands already broadcast in the insertion cycle
    always_comb begin
        insSlot = insData;
        if (insData.qjWait && robValid[insData.qj]) begin
            insSlot.vj     = robValue[insData.qj*DATA_W +: DATA_W];
            insSlot.qjWait = 1'b0;
        end
        if (insData.qkWait && robValid[insData.qk]) begin
            insSlot.vk     = robValue[insData.qk*DATA_W +: DATA_W];
            insSlot.qkWait = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (busy[i] && slots[i].qjWait && robValid[slots[i].qj]) begin
                slots[i].vj     <= robValue[slots[i].qj*DATA_W +: DATA_W];
                slots[i].qjWait <= 1'b0;
            end
            if (busy[i] && slots[i].qkWait && robValid[slots[i].qk]) begin
                slots[i].vk     <= robValue[slots[i].qk*DATA_W +: DATA_W];
                slots[i].qkWait <= 1'b0;
            end
        end
        if (doInsert)
            slots[freeSlot] <= insSlot;
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            busy   <= '0;
            ready  <= '0;
            issued <= '0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (busy[i] && !issued[i] && !slots[i].qjWait && !slots[i].qkWait)
                    ready[i] <= 1'b1;
            end
            if (issue.take) begin
                ready[issue.pickSlot]  <= 1'b0;
                issued[issue.pickSlot] <= 1'b1;
            end
            if (issue.releaseValid) begin
                busy[issue.releaseSlot]   <= 1'b0;
                ready[issue.releaseSlot]  <= 1'b0;
                issued[issue.releaseSlot] <= 1'b0;
            end
            if (doInsert) begin
                busy[freeSlot]   <= 1'b1;
                ready[freeSlot]  <= 1'b0;
                issued[freeSlot] <= 1'b0;
            end
        end
    end

    insertFreeSlot: assert property (@(posedge clk) disable iff (rst)
        doInsert |-> !busy[freeSlot]);

endmodule

`default_nettype wire

// ==== rsIssueIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface rsIssueIf #(
    parameter int RS_SIZE = 16
);
    import rsPkg::*;

    localparam int IDX_W = $clog2(RS_SIZE);

    logic             pickValid;
    logic [IDX_W-1:0] pickSlot;
    rsSlot            pickData;
    logic             take;         // Issue pickSlot this cycle
    logic             releaseValid; // Free releaseSlot this cycle
    logic [IDX_W-1:0] releaseSlot;

    modport entryTable (output pickValid, pickSlot, pickData,
                        input  take, releaseValid, releaseSlot);

    modport dispatch (input  pickValid, pickSlot, pickData,
                      output take, releaseValid, releaseSlot);

endinterface

`default_nettype wire

// ==== rsPkg.sv ====
`default_nettype none

package rsPkg;

    localparam int DATA_W   = 32;
    localparam int ROB_SIZE = 16;

    typedef logic [3:0]        robTag;
    typedef logic [DATA_W-1:0] dataWord;

    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        ADDI, ANDI, ORI, XORI, SLLI, SRLI, SRAI, SLTI, SLTIU,
        LUI, AUIPC,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR
    } instrName;

    // Compare codes leave 0/1 in bit 0 of the result
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
        OP_LT, OP_LTU, OP_GE, OP_GEU, OP_EQ, OP_NE
    } aluOp;

    typedef struct packed {
        instrName name;
        dataWord  vj;
        dataWord  vk;
        dataWord  imm;   // Bit 0 holds the prediction for branches
        robTag    qj;
        robTag    qk;
        logic     qjWait;
        logic     qkWait;
        dataWord  rd;
        robTag    tag;
    } rsSlot;

    function automatic logic isBranch(instrName n);
        return n inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    function automatic logic isStore(instrName n);
        return n inside {SB, SH, SW};
    endfunction

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_reservationStation -f vlog.f

./obj_dir/Vtb_reservationStation | tee sim.log

if grep -q "Test OK" sim.log; then
    exit 0
fi
exit 1

// ==== slotPicker.sv ====
`timescale 1ns/1ns
`default_nettype none

module slotPicker #(
    parameter int RS_SIZE = 16
) (
    input  logic [RS_SIZE-1:0]         busy,
    input  logic [RS_SIZE-1:0]         ready,
    output logic [$clog2(RS_SIZE)-1:0] freeSlot,
    output logic                       hasFree,
    output logic [$clog2(RS_SIZE)-1:0] readySlot,
    output logic                       hasReady
);

    localparam int IDX_W = $clog2(RS_SIZE);

    logic [RS_SIZE-1:0] candidate;

    assign candidate = ready & busy;
    assign hasFree   = ~&busy;
    assign hasReady  = |candidate;

    // Walk downwards so the lowest index is written last
    always_comb begin
        freeSlot  = '0;
        readySlot = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i])
                freeSlot = IDX_W'(i);
            if (candidate[i])
                readySlot = IDX_W'(i);
        end
    end

endmodule

`default_nettype wire

// ==== tb_reservationStation.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_reservationStation;
    import rsPkg::*;

    localparam int RS_SIZE        = 8;    // Small enough for RS_SIZE + 1 distinct tags
    localparam int TIMEOUT_CYCLES = 4000;

    logic                         clk;
    logic                         rst;
    logic                         clr;
    logic                         insValid;
    instrName                     name;
    dataWord                      vj;
    dataWord                      vk;
    robTag                        qj;
    logic                         qjWait;
    robTag                        qk;
    logic                         qkWait;
    dataWord                      imm;
    dataWord                      rd;
    robTag                        tag;
    logic [ROB_SIZE-1:0]          robValid;
    logic [ROB_SIZE*DATA_W-1:0]   robValue;
    logic                         rsFull;
    logic                         aluReady;
    dataWord                      lv;
    dataWord                      rv;
    aluOp                         op;
    logic                         aluSuccess;
    dataWord                      result;
    logic                         robReady;
    robTag                        robAddr;
    dataWord                      robA;
    dataWord                      robRd;
    logic                         trainReady;
    logic                         trainResult;

    int                  seed;
    int                  cycleCount;
    int                  flushCount;
    logic                aluHold;      // Withholds aluSuccess while set
    rsSlot               expRec [ROB_SIZE];
    logic [ROB_SIZE-1:0] expPending;
    logic [ROB_SIZE-1:0] committed;

    reservationStation #(
        .RS_SIZE (RS_SIZE)
    ) u_reservationStation (
        .clk (clk), .rst (rst), .clr (clr),
        .insValid (insValid), .name (name), .vj (vj), .vk (vk),
        .qj (qj), .qjWait (qjWait), .qk (qk), .qkWait (qkWait),
        .imm (imm), .rd (rd), .tag (tag),
        .robValid (robValid), .robValue (robValue), .rsFull (rsFull),
        .aluReady (aluReady), .lv (lv), .rv (rv), .op (op),
        .aluSuccess (aluSuccess), .result (result),
        .robReady (robReady), .robAddr (robAddr), .robA (robA), .robRd (robRd),
        .trainReady (trainReady), .trainResult (trainResult)
    );

    always #10 clk = ~clk;

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stopWithError($sformatf("ERR %0t: %s got %h, expected %h", $time, what, got, exp));
    endtask

    function automatic dataWord aluRef(aluOp o, dataWord a, dataWord b);
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return $signed(a) >>> b[4:0];
            OP_LT:   return {31'b0, $signed(a) < $signed(b)};
            OP_LTU:  return {31'b0, a < b};
            OP_GE:   return {31'b0, $signed(a) >= $signed(b)};
            OP_GEU:  return {31'b0, a >= b};
            OP_EQ:   return {31'b0, a == b};
            OP_NE:   return {31'b0, a != b};
            default: return '0;
        endcase
    endfunction

    function automatic aluOp opFor(instrName n);
        if (n inside {SUB})                      return OP_SUB;
        if (n inside {AND, ANDI})                return OP_AND;
        if (n inside {OR, ORI})                  return OP_OR;
        if (n inside {XOR, XORI})                return OP_XOR;
        if (n inside {SLL, SLLI})                return OP_SLL;
        if (n inside {SRL, SRLI})                return OP_SRL;
        if (n inside {SRA, SRAI})                return OP_SRA;
        if (n inside {SLT, SLTI, BLT})           return OP_LT;
        if (n inside {SLTU, SLTIU, BLTU})        return OP_LTU;
        if (n == BGE)                            return OP_GE;
        if (n == BGEU)                           return OP_GEU;
        if (n == BEQ)                            return OP_EQ;
        if (n == BNE)                            return OP_NE;
        return OP_ADD;                           // Adds, memory, upper imm, jumps
    endfunction

    function automatic void expectWrite(input rsSlot s, output dataWord a, output dataWord r,
                                        output logic isBr, output logic train);
        dataWord  l;
        dataWord  rgt;
        dataWord  res;
        instrName n;
        n    = s.name;
        isBr = n inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
        l    = s.vj;
        rgt  = s.imm;
        if (isBr || n inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU})
            rgt = s.vk;
        else if (n == LUI)
            l = '0;
        else if (n == AUIPC)
            rgt = {s.imm[31:12], 12'h0};
        else if (n == JAL) begin
            l   = s.vk;
            rgt = {s.imm[31:1], 1'b0};
        end
        res = aluRef(opFor(n), l, rgt);
        if (n inside {SB, SH, SW}) begin
            a = s.vk;
            r = res;
        end else begin
            a = res;
            r = s.rd;
        end
        train = s.imm[0] ^ res[0];
    endfunction

    function automatic rsSlot makeSlot(instrName n, dataWord a, dataWord b, dataWord i,
                                       robTag t);
        rsSlot s;
        s      = '0;
        s.name = n;
        s.vj   = a;
        s.vk   = b;
        s.imm  = i;
        s.tag  = t;
        s.rd   = 32'h100 + 32'(t);
        return s;
    endfunction

    task automatic randomSlot(input int k, input robTag t, output rsSlot s);
        s      = makeSlot(instrName'(k % 37), $random(seed), $random(seed), $random(seed), t);
        s.rd   = $random(seed);
        s.qj   = robTag'($random(seed));  // Ignored, nothing waits
        s.qk   = robTag'($random(seed));
    endtask

    function automatic void recordExpect(input rsSlot s);
        expRec[s.tag]     = s;
        expPending[s.tag] = 1'b1;
        committed[s.tag]  = 1'b0;
    endfunction

    task automatic insertInstr(input rsSlot s, input logic waitFree, input logic bcast,
                               input robTag bTag, input dataWord bVal);
        @(negedge clk);
        while (waitFree && rsFull)
            @(negedge clk);
        @(posedge clk);
        insValid <= 1'b1;
        name     <= s.name;
        vj       <= s.vj;
        vk       <= s.vk;
        qj       <= s.qj;
        qjWait   <= s.qjWait;
        qk       <= s.qk;
        qkWait   <= s.qkWait;
        imm      <= s.imm;
        rd       <= s.rd;
        tag      <= s.tag;
        if (bcast) begin
            robValid[bTag]                   <= 1'b1;
            robValue[bTag*DATA_W +: DATA_W] <= bVal;
        end
        @(posedge clk);
        insValid <= 1'b0;
        robValid <= '0;
    endtask

    task automatic broadcast(input robTag t, input dataWord v);
        @(posedge clk);
        robValid[t]                   <= 1'b1;
        robValue[t*DATA_W +: DATA_W] <= v;
        @(posedge clk);
        robValid <= '0;
    endtask

    task automatic waitDrain();
        @(negedge clk);
        while (expPending != '0)
            @(negedge clk);
    endtask

    task automatic flushStation();
        @(posedge clk);
        clr <= 1'b1;
        flushCount++;
        expPending = '0;   // Flushed work must never commit
        @(posedge clk);
        clr <= 1'b0;
    endtask

    // ALU model, one operation at a time
    initial begin : aluModel
        aluOp    curOp;
        dataWord curL;
        dataWord curR;
        int      delay;
        int      flushMark;
        forever begin
            @(negedge clk);
            if (aluReady) begin
                curOp     = op;
                curL      = lv;
                curR      = rv;
                flushMark = flushCount;
                delay     = 1 + ({$random(seed)} % 3);
                repeat (delay) @(posedge clk);
                while (aluHold)
                    @(posedge clk);
                if (flushMark == flushCount) begin
                    aluSuccess <= 1'b1;
                    result     <= aluRef(curOp, curL, curR);
                    @(posedge clk);
                    aluSuccess <= 1'b0;
                end
            end
        end
    end

    always @(negedge clk) begin : commitChecker
        dataWord eA;
        dataWord eRd;
        logic    eBr;
        logic    eTrain;
        if (!rst) begin
            if (trainReady && !robReady)
                stopWithError("trainReady was high without robReady");
            if (robReady) begin
                if (!expPending[robAddr]) begin
                    if (committed[robAddr])
                        stopWithError($sformatf("Tag %0d committed more than once", robAddr));
                    else
                        stopWithError($sformatf("Commit for tag %0d that is not pending",
                                                robAddr));
                end
                expectWrite(expRec[robAddr], eA, eRd, eBr, eTrain);
                checkEq("robA", robA, eA);
                checkEq("robRd", robRd, eRd);
                checkEq("trainReady", 32'(trainReady), 32'(eBr));
                if (eBr)
                    checkEq("trainResult", 32'(trainResult), 32'(eTrain));
                expPending[robAddr] = 1'b0;
                committed[robAddr]  = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
            stopWithError($sformatf("Timeout after %0d cycles, commits stopped", cycleCount));
    end

    initial begin : stimulus
        rsSlot s;
        rsSlot e;
        clk        = 1'b0;
        rst        = 1'b1;
        clr        = 1'b0;
        insValid   = 1'b0;
        name       = ADD;
        vj         = '0;
        vk         = '0;
        qj         = '0;
        qjWait     = 1'b0;
        qk         = '0;
        qkWait     = 1'b0;
        imm        = '0;
        rd         = '0;
        tag        = '0;
        robValid   = '0;
        robValue   = '0;
        aluSuccess = 1'b0;
        result     = '0;
        seed       = 40;
        cycleCount = 0;
        flushCount = 0;
        aluHold    = 1'b0;
        expPending = '0;
        committed  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Every instruction kind with random operands
        for (int b = 0; b < 3; b++) begin
            for (int t = 0; t < 16; t++) begin
                randomSlot(b * 16 + t, robTag'(t), s);
                recordExpect(s);
                insertInstr(s, 1'b1, 1'b0, '0, '0);
            end
            waitDrain();
        end

        // Late wakeup from the ROB bus
        s = makeSlot(SUB, 32'hDEAD_0001, 32'h10, '0, 4'd0);
        s.qj     = 4'd5;
        s.qjWait = 1'b1;
        e    = s;
        e.vj = 32'h1234_5678;
        recordExpect(e);
        insertInstr(s, 1'b1, 1'b0, '0, '0);
        s = makeSlot(XOR, 32'hDEAD_0002, 32'hDEAD_0003, '0, 4'd1);
        s.qj     = 4'd5;
        s.qjWait = 1'b1;
        s.qk     = 4'd6;
        s.qkWait = 1'b1;
        e    = s;
        e.vj = 32'h1234_5678;
        e.vk = 32'h0F0F_00FF;
        recordExpect(e);
        insertInstr(s, 1'b1, 1'b0, '0, '0);
        repeat (5) @(posedge clk);
        broadcast(4'd5, 32'h1234_5678);
        repeat (3) @(posedge clk);
        broadcast(4'd6, 32'h0F0F_00FF);

        // Broadcast in the insertion cycle
        s = makeSlot(BLT, 32'hDEAD_0004, 32'h5, 32'h1, 4'd2);
        s.qj     = 4'd7;
        s.qjWait = 1'b1;
        e    = s;
        e.vj = 32'hFFFF_FFF0;
        recordExpect(e);
        insertInstr(s, 1'b1, 1'b1, 4'd7, 32'hFFFF_FFF0);
        waitDrain();

        // Branches with both prediction values
        recordExpect(makeSlot(BEQ, 32'd5, 32'd5, 32'd0, 4'd3));
        recordExpect(makeSlot(BNE, 32'd1, 32'd2, 32'd1, 4'd4));
        recordExpect(makeSlot(BGEU, 32'd1, 32'd2, 32'd1, 4'd5));
        recordExpect(makeSlot(BLT, 32'hFFFF_FFFF, 32'd1, 32'd0, 4'd6));
        for (int t = 3; t < 7; t++)
            insertInstr(expRec[t], 1'b1, 1'b0, '0, '0);
        waitDrain();

        // Full station drops the extra insert
        aluHold = 1'b1;
        for (int t = 0; t < RS_SIZE; t++) begin
            randomSlot(t + 5, robTag'(t), s);
            recordExpect(s);
            insertInstr(s, 1'b1, 1'b0, '0, '0);
        end
        @(negedge clk);
        checkEq("rsFull", 32'(rsFull), 32'd1);
        randomSlot(7, robTag'(RS_SIZE), s);
        insertInstr(s, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        checkEq("rsFull", 32'(rsFull), 32'd1);
        aluHold = 1'b0;
        waitDrain();
        repeat (20) @(negedge clk);

        // Flush with work pending
        aluHold = 1'b1;
        for (int t = 0; t < RS_SIZE; t++) begin
            randomSlot(t + 20, robTag'(t), s);
            recordExpect(s);
            insertInstr(s, 1'b1, 1'b0, '0, '0);
        end
        flushStation();
        @(negedge clk);
        checkEq("rsFull", 32'(rsFull), 32'd0);
        aluHold = 1'b0;
        repeat (20) @(negedge clk);
        for (int t = 8; t < 12; t++) begin
            randomSlot(t, robTag'(t), s);
            recordExpect(s);
            insertInstr(s, 1'b1, 1'b0, '0, '0);
        end
        waitDrain();

        @(negedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rsPkg.sv
rsIssueIf.sv
slotPicker.sv
rsEntryTable.sv
aluDispatch.sv
commitUnit.sv
reservationStation.sv
tb_reservationStation.sv
